/* src/ifu_pkg.sv */
`default_nettype none

package ifu_pkg;

  // Datapath widths
  localparam int XLEN    = 32;
  localparam int ORDER_W = 64;
  localparam int ERA_W   = 4;

  // Request and data queues
  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_AFULL = 6;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

  // Requests still owed an ack, old eras included
  localparam int OUTST_W = 5;

  // Branch target buffer, indexed by PC[5:2]
  localparam int BTB_ENTRIES = 16;
  localparam int BTB_IDX_W   = $clog2(BTB_ENTRIES);
  localparam int BTB_TAG_W   = XLEN - BTB_IDX_W - 2;

  // One issued fetch as recorded in the request queue
  typedef struct packed {
    logic [ORDER_W-1:0] order;
    logic [XLEN-1:0]    pc;
    logic               br_taken;
    logic [XLEN-1:0]    pred_next;
  } fetch_req_t;

endpackage

`default_nettype wire

/* src/ifu_fifo.sv */
`default_nettype none

module ifu_fifo
  import ifu_pkg::*;
#(
  parameter type T = logic [XLEN-1:0]
)
(
  input  logic clk,
  input  logic rst,
  input  logic clr_i,
  input  logic push_i,
  input  T     data_i,
  input  logic pop_i,
  output T     data_o,
  output logic empty_o,
  output logic afull_o
);

  T                      mem_q [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr_q;
  logic [FIFO_PTR_W-1:0] rd_ptr_q;
  logic [FIFO_CNT_W-1:0] count_q;

  function automatic logic [FIFO_PTR_W-1:0] next_ptr(input logic [FIFO_PTR_W-1:0] ptr);
    if (ptr == FIFO_PTR_W'(FIFO_DEPTH - 1))
      begin
      return '0;
      end
    return ptr + 1'b1;
  endfunction

  // Head is shown without a register stage
  assign data_o  = mem_q[rd_ptr_q];
  assign empty_o = (count_q == '0);
  assign afull_o = (count_q >= FIFO_CNT_W'(FIFO_AFULL));

  always_ff @(posedge clk)
    begin
    if (push_i)
      begin
      mem_q[wr_ptr_q] <= data_i;
      end
    end

  always_ff @(posedge clk)
    begin
    if (rst || clr_i)
      begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      end
    else
      begin
      if (push_i)
        begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
        end
      if (pop_i)
        begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
        end
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      end
    end

  a_no_push_full: assert property (@(posedge clk) disable iff (rst)
    push_i && !clr_i |-> count_q != FIFO_CNT_W'(FIFO_DEPTH));

  a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
    pop_i && !clr_i |-> !empty_o);

endmodule

`default_nettype wire

/* src/ifu_btb.sv */
`default_nettype none

module ifu_btb
  import ifu_pkg::*;
(
  input  logic            clk,
  input  logic            rst,

  input  logic [XLEN-1:0] lookup_pc_i,
  output logic            hit_o,
  output logic [XLEN-1:0] target_o,

  input  logic            upd_vld_i,
  input  logic [XLEN-1:0] upd_pc_i,
  input  logic [XLEN-1:0] upd_target_i
);

  logic [BTB_ENTRIES-1:0] valid_q;
  logic [BTB_TAG_W-1:0]   tag_q [BTB_ENTRIES];
  logic [XLEN-1:0]        target_q [BTB_ENTRIES];

  logic [BTB_IDX_W-1:0]   lkp_idx;
  logic [BTB_TAG_W-1:0]   lkp_tag;
  logic [BTB_IDX_W-1:0]   upd_idx;
  logic [BTB_TAG_W-1:0]   upd_tag;

  // Word aligned PCs, so bits 1:0 never take part
  assign lkp_idx = lookup_pc_i[BTB_IDX_W+1:2];
  assign lkp_tag = lookup_pc_i[XLEN-1:BTB_IDX_W+2];
  assign upd_idx = upd_pc_i[BTB_IDX_W+1:2];
  assign upd_tag = upd_pc_i[XLEN-1:BTB_IDX_W+2];

  // Same cycle lookup for the fetch controller
  assign hit_o    = valid_q[lkp_idx] && (tag_q[lkp_idx] == lkp_tag);
  assign target_o = target_q[lkp_idx];

  always_ff @(posedge clk)
    begin
    if (rst)
      begin
      valid_q <= '0;
      end
    else if (upd_vld_i)
      begin
      valid_q[upd_idx] <= 1'b1;
      end
    end

  // A resolved branch replaces whatever held its line
  always_ff @(posedge clk)
    begin
    if (upd_vld_i)
      begin
      tag_q[upd_idx]    <= upd_tag;
      target_q[upd_idx] <= upd_target_i;
      end
    end

endmodule

`default_nettype wire

/* src/ifu_fetch_ctrl.sv */
`default_nettype none

module ifu_fetch_ctrl
  import ifu_pkg::*;
(
  input  logic               clk,
  input  logic               rst,

  input  logic               exu_redir_i,
  input  logic [XLEN-1:0]    exu_pc_next_i,
  input  logic [ORDER_W-1:0] exu_order_next_i,

  input  logic               req_afull_i,
  input  logic               btb_hit_i,
  input  logic [XLEN-1:0]    btb_target_i,
  output logic [XLEN-1:0]    lookup_pc_o,

  output logic               req_push_o,
  output fetch_req_t         req_o,

  output logic               bus_stb_o,
  output logic               bus_cyc_o,
  output logic [XLEN-1:0]    bus_adr_o,
  output logic               bus_tga_o,
  output logic [ERA_W-1:0]   bus_tgc_o,
  input  logic               bus_stall_i,
  input  logic               bus_ack_i,
  input  logic [XLEN-1:0]    bus_dat_i,
  input  logic [ERA_W-1:0]   bus_tgc_i,

  output logic               data_push_o,
  output logic [XLEN-1:0]    data_o,
  output logic               flush_o
);

  logic [XLEN-1:0]    pc_q;
  logic [ORDER_W-1:0] order_q;
  logic [ERA_W-1:0]   era_q;
  logic               flush_q;
  logic               issue_en_q;
  logic [OUTST_W-1:0] outst_q;
  logic               rsp_vld_q;
  logic [XLEN-1:0]    rsp_dat_q;
  logic               accept;
  logic [XLEN-1:0]    pc_next;

  assign pc_next = btb_hit_i ? btb_target_i : pc_q + XLEN'(4);

  // The queue clear in the flush cycle would drop any push made then
  assign bus_stb_o = issue_en_q & ~flush_q & ~req_afull_i;
  assign accept    = bus_stb_o & ~bus_stall_i;
  // Cycle stays open until every old ack is back
  assign bus_cyc_o = bus_stb_o | (outst_q != '0);
  assign bus_adr_o = pc_q;
  assign bus_tga_o = btb_hit_i;
  assign bus_tgc_o = era_q;

  assign lookup_pc_o = pc_q;
  assign req_push_o  = accept;
  assign req_o       = '{order: order_q, pc: pc_q, br_taken: btb_hit_i, pred_next: pc_next};

  assign data_push_o = rsp_vld_q;
  assign data_o      = rsp_dat_q;
  assign flush_o     = flush_q;

  always_ff @(posedge clk)
    begin
    if (rst)
      begin
      pc_q       <= '0;
      order_q    <= '0;
      era_q      <= '0;
      flush_q    <= 1'b0;
      issue_en_q <= 1'b0;
      rsp_vld_q  <= 1'b0;
      end
    else
      begin
      issue_en_q <= 1'b1;
      flush_q    <= exu_redir_i;
      // Stale eras are dropped here
      rsp_vld_q  <= bus_ack_i && (bus_tgc_i == era_q);
      if (exu_redir_i)
        begin
        pc_q    <= exu_pc_next_i;
        order_q <= exu_order_next_i;
        era_q   <= era_q + 1'b1;
        end
      else if (accept)
        begin
        pc_q    <= pc_next;
        order_q <= order_q + 1'b1;
        end
      end
    end

  always_ff @(posedge clk)
    begin
    rsp_dat_q <= bus_dat_i;
    end

  always_ff @(posedge clk)
    begin
    if (rst)
      begin
      outst_q <= '0;
      end
    else
      begin
      case ({accept, bus_ack_i})
        2'b10:   outst_q <= outst_q + 1'b1;
        2'b01:   outst_q <= outst_q - 1'b1;
        default: outst_q <= outst_q;
      endcase
      end
    end

  // Slave may only answer a request it has taken
  a_ack_owed: assert property (@(posedge clk) disable iff (rst)
    bus_ack_i |-> outst_q != '0);

endmodule

`default_nettype wire

/* src/ifu_deliver.sv */
`default_nettype none

module ifu_deliver
  import ifu_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  logic               flush_i,

  input  logic               req_empty_i,
  input  fetch_req_t         req_i,
  input  logic               data_empty_i,
  input  logic [XLEN-1:0]    data_i,
  output logic               pop_o,

  input  logic               ifu_rdy_i,
  output logic               ifu_vld_o,
  output logic [XLEN-1:0]    ifu_inst_o,
  output logic [XLEN-1:0]    ifu_pc_o,
  output logic [ORDER_W-1:0] ifu_order_o,
  output logic               ifu_br_taken_o,
  output logic [XLEN-1:0]    ifu_pred_next_o
);

  logic vld_q;

  // Both heads together, and only when the output slot frees up
  assign pop_o = ~req_empty_i & ~data_empty_i & ~flush_i & (~vld_q | ifu_rdy_i);

  // Old path entry must not reach decode in the flush cycle
  assign ifu_vld_o = vld_q & ~flush_i;

  always_ff @(posedge clk)
    begin
    if (rst || flush_i)
      begin
      vld_q <= 1'b0;
      end
    else if (pop_o)
      begin
      vld_q <= 1'b1;
      end
    else if (ifu_rdy_i)
      begin
      vld_q <= 1'b0;
      end
    end

  always_ff @(posedge clk)
    begin
    if (pop_o)
      begin
      ifu_inst_o      <= data_i;
      ifu_pc_o        <= req_i.pc;
      ifu_order_o     <= req_i.order;
      ifu_br_taken_o  <= req_i.br_taken;
      ifu_pred_next_o <= req_i.pred_next;
      end
    end

  a_hold_stalled: assert property (@(posedge clk) disable iff (rst)
    ifu_vld_o && !ifu_rdy_i |=> (ifu_vld_o || flush_i)
      && $stable(ifu_inst_o) && $stable(ifu_pc_o) && $stable(ifu_order_o)
      && $stable(ifu_br_taken_o) && $stable(ifu_pred_next_o));

endmodule

`default_nettype wire

/* src/ifu_top.sv */
`default_nettype none

// Bus error and retry are not handled; the slave is expected to never raise them
module ifu_top
  import ifu_pkg::*;
(
  input  logic               clk,
  input  logic               rst,

  input  logic               exu_redir_i,
  input  logic [XLEN-1:0]    exu_pc_next_i,
  input  logic [ORDER_W-1:0] exu_order_next_i,
  input  logic               exu_upd_vld_i,
  input  logic [XLEN-1:0]    exu_upd_pc_i,
  input  logic [XLEN-1:0]    exu_upd_target_i,

  output logic               bus_stb_o,
  output logic               bus_cyc_o,
  output logic [XLEN-1:0]    bus_adr_o,
  output logic               bus_tga_o,
  output logic [ERA_W-1:0]   bus_tgc_o,
  input  logic               bus_stall_i,
  input  logic               bus_ack_i,
  input  logic [XLEN-1:0]    bus_dat_i,
  input  logic [ERA_W-1:0]   bus_tgc_i,

  input  logic               ifu_rdy_i,
  output logic               ifu_vld_o,
  output logic [XLEN-1:0]    ifu_inst_o,
  output logic [XLEN-1:0]    ifu_pc_o,
  output logic [ORDER_W-1:0] ifu_order_o,
  output logic               ifu_br_taken_o,
  output logic [XLEN-1:0]    ifu_pred_next_o
);

  logic [XLEN-1:0] lookup_pc;
  logic            btb_hit;
  logic [XLEN-1:0] btb_target;

  logic            flush;
  logic            pop;

  logic            req_push;
  fetch_req_t      req_in;
  fetch_req_t      req_head;
  logic            req_empty;
  logic            req_afull;

  logic            data_push;
  logic [XLEN-1:0] data_in;
  logic [XLEN-1:0] data_head;
  logic            data_empty;

  ifu_fetch_ctrl fetch_ctrl0 (
    .clk              ( clk              ),
    .rst              ( rst              ),
    .exu_redir_i      ( exu_redir_i      ),
    .exu_pc_next_i    ( exu_pc_next_i    ),
    .exu_order_next_i ( exu_order_next_i ),
    .req_afull_i      ( req_afull        ),
    .btb_hit_i        ( btb_hit          ),
    .btb_target_i     ( btb_target       ),
    .lookup_pc_o      ( lookup_pc        ),
    .req_push_o       ( req_push         ),
    .req_o            ( req_in           ),
    .bus_stb_o        ( bus_stb_o        ),
    .bus_cyc_o        ( bus_cyc_o        ),
    .bus_adr_o        ( bus_adr_o        ),
    .bus_tga_o        ( bus_tga_o        ),
    .bus_tgc_o        ( bus_tgc_o        ),
    .bus_stall_i      ( bus_stall_i      ),
    .bus_ack_i        ( bus_ack_i        ),
    .bus_dat_i        ( bus_dat_i        ),
    .bus_tgc_i        ( bus_tgc_i        ),
    .data_push_o      ( data_push        ),
    .data_o           ( data_in          ),
    .flush_o          ( flush            )
  );

  ifu_btb btb0 (
    .clk          ( clk              ),
    .rst          ( rst              ),
    .lookup_pc_i  ( lookup_pc        ),
    .hit_o        ( btb_hit          ),
    .target_o     ( btb_target       ),
    .upd_vld_i    ( exu_upd_vld_i    ),
    .upd_pc_i     ( exu_upd_pc_i     ),
    .upd_target_i ( exu_upd_target_i )
  );

  ifu_fifo #(.T(fetch_req_t)) req_q (
    .clk     ( clk       ),
    .rst     ( rst       ),
    .clr_i   ( flush     ),
    .push_i  ( req_push  ),
    .data_i  ( req_in    ),
    .pop_i   ( pop       ),
    .data_o  ( req_head  ),
    .empty_o ( req_empty ),
    .afull_o ( req_afull )
  );

  // Never fuller than req_q, so its almost-full goes unused
  ifu_fifo #(.T(logic [XLEN-1:0])) data_q (
    .clk     ( clk        ),
    .rst     ( rst        ),
    .clr_i   ( flush      ),
    .push_i  ( data_push  ),
    .data_i  ( data_in    ),
    .pop_i   ( pop        ),
    .data_o  ( data_head  ),
    .empty_o ( data_empty ),
    .afull_o (            )
  );

  ifu_deliver deliver0 (
    .clk             ( clk             ),
    .rst             ( rst             ),
    .flush_i         ( flush           ),
    .req_empty_i     ( req_empty       ),
    .req_i           ( req_head        ),
    .data_empty_i    ( data_empty      ),
    .data_i          ( data_head       ),
    .pop_o           ( pop             ),
    .ifu_rdy_i       ( ifu_rdy_i       ),
    .ifu_vld_o       ( ifu_vld_o       ),
    .ifu_inst_o      ( ifu_inst_o      ),
    .ifu_pc_o        ( ifu_pc_o        ),
    .ifu_order_o     ( ifu_order_o     ),
    .ifu_br_taken_o  ( ifu_br_taken_o  ),
    .ifu_pred_next_o ( ifu_pred_next_o )
  );

endmodule

`default_nettype wire

/* tests/ifu_bus_model.sv */
`default_nettype none

module ifu_bus_model
  import ifu_pkg::*;
#(
  parameter logic [31:0] SEED = 32'ha8ec7cbe
)
(
  input  logic             clk,
  input  logic             rst,
  input  logic             stall_en_i,
  input  logic             stb_i,
  input  logic [XLEN-1:0]  adr_i,
  input  logic [ERA_W-1:0] tgc_i,
  output logic             stall_o,
  output logic             ack_o,
  output logic [XLEN-1:0]  dat_o,
  output logic [ERA_W-1:0] tgc_o
);

  timeunit 1ns;
  timeprecision 100ps;

  logic             stall_q = 1'b0;
  logic             ack_q = 1'b0;
  logic [XLEN-1:0]  dat_q = '0;
  logic [ERA_W-1:0] tgc_q = '0;

  integer           seed = SEED;
  logic [XLEN-1:0]  q_adr [$];
  logic [ERA_W-1:0] q_tgc [$];
  int               q_due [$];
  int               cyc;
  int               last_due;
  int               lat;
  int               due;
  logic             stall_on;

  assign stall_o = stall_q;
  assign ack_o   = ack_q;
  assign dat_o   = dat_q;
  assign tgc_o   = tgc_q;

  // Requests are sampled at the edge, responses are driven just after it
  always @(posedge clk)
    begin
    stall_on = stall_en_i && !rst;
    if (rst)
      begin
      q_adr.delete();
      q_tgc.delete();
      q_due.delete();
      cyc      = 0;
      last_due = 0;
      end
    else
      begin
      cyc = cyc + 1;
      if (ack_q)
        begin
        void'(q_adr.pop_front());
        void'(q_tgc.pop_front());
        void'(q_due.pop_front());
        end
      if (stb_i && !stall_q)
        begin
        lat = 1 + ($unsigned($random(seed)) % 4);
        due = cyc + lat - 1;
        // In order, at most one ack per cycle
        if (due <= last_due)
          begin
          due = last_due + 1;
          end
        last_due = due;
        q_adr.push_back(adr_i);
        q_tgc.push_back(tgc_i);
        q_due.push_back(due);
        end
      end
    #1;
    if (q_due.size() > 0 && q_due[0] <= cyc)
      begin
      ack_q = 1'b1;
      dat_q = q_adr[0] ^ 32'h5a5a0000;
      tgc_q = q_tgc[0];
      end
    else
      begin
      ack_q = 1'b0;
      dat_q = '0;
      end
    stall_q = stall_on && (($random(seed) & 3) == 0);
    end

endmodule

`default_nettype wire

/* tests/ifu_tb.sv */
`default_nettype none

module ifu_tb
  import ifu_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_TESTS = 5;
  localparam int TIMEOUT   = 200 * NUM_TESTS;

  logic               clk;
  logic               rst;
  logic               exu_redir;
  logic [XLEN-1:0]    exu_pc_next;
  logic [ORDER_W-1:0] exu_order_next;
  logic               exu_upd_vld;
  logic [XLEN-1:0]    exu_upd_pc;
  logic [XLEN-1:0]    exu_upd_target;
  logic               stall_en;
  logic               ifu_rdy;

  logic               bus_stb;
  logic               bus_cyc;
  logic [XLEN-1:0]    bus_adr;
  logic               bus_tga;
  logic [ERA_W-1:0]   bus_tgc;
  logic               bus_stall;
  logic               bus_ack;
  logic [XLEN-1:0]    bus_dat;
  logic [ERA_W-1:0]   bus_tgc_rsp;

  logic               ifu_vld;
  logic [XLEN-1:0]    ifu_inst;
  logic [XLEN-1:0]    ifu_pc;
  logic [ORDER_W-1:0] ifu_order;
  logic               ifu_br_taken;
  logic [XLEN-1:0]    ifu_pred_next;
  fetch_req_t         out_req;

  integer             seed = 32'ha8ec7cbe;
  int                 cycles = 0;
  int                 errors = 0;
  int                 checks = 0;
  int                 tests_run = 0;
  int                 err_base;
  string              cur_test = "reset";

  // Delivered transfers of the running test
  fetch_req_t         cap_req [$];
  logic [XLEN-1:0]    cap_inst [$];

  // Trained branch target as execute wrote it
  logic               trn_vld = 1'b0;
  logic [XLEN-1:0]    trn_pc;
  logic [XLEN-1:0]    trn_target;

  // Era the next request carries, and requests still owed an ack
  logic [ERA_W-1:0]   exp_era = '0;
  int                 outst = 0;

  logic               held = 1'b0;
  fetch_req_t         held_req;
  logic [XLEN-1:0]    held_inst;

  ifu_top dut0 (
    .clk (clk), .rst (rst),
    .exu_redir_i (exu_redir), .exu_pc_next_i (exu_pc_next),
    .exu_order_next_i (exu_order_next), .exu_upd_vld_i (exu_upd_vld),
    .exu_upd_pc_i (exu_upd_pc), .exu_upd_target_i (exu_upd_target),
    .bus_stb_o (bus_stb), .bus_cyc_o (bus_cyc), .bus_adr_o (bus_adr),
    .bus_tga_o (bus_tga), .bus_tgc_o (bus_tgc), .bus_stall_i (bus_stall),
    .bus_ack_i (bus_ack), .bus_dat_i (bus_dat), .bus_tgc_i (bus_tgc_rsp),
    .ifu_rdy_i (ifu_rdy), .ifu_vld_o (ifu_vld), .ifu_inst_o (ifu_inst),
    .ifu_pc_o (ifu_pc), .ifu_order_o (ifu_order), .ifu_br_taken_o (ifu_br_taken),
    .ifu_pred_next_o (ifu_pred_next)
  );

  ifu_bus_model #(.SEED(32'ha8ec7cbe)) bus0 (
    .clk (clk), .rst (rst), .stall_en_i (stall_en),
    .stb_i (bus_stb), .adr_i (bus_adr), .tgc_i (bus_tgc),
    .stall_o (bus_stall), .ack_o (bus_ack), .dat_o (bus_dat), .tgc_o (bus_tgc_rsp)
  );

  assign out_req = '{order: ifu_order, pc: ifu_pc, br_taken: ifu_br_taken,
                     pred_next: ifu_pred_next};

  initial
    begin
    clk = 1'b0;
    forever #2 clk = ~clk;
    end

  always @(posedge clk)
    begin
    cycles = cycles + 1;
    if (cycles == TIMEOUT)
      begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT);
      $display("FAIL: see errors above");
      $finish;
      end
    end

  task automatic check_req(input string name, input fetch_req_t exp, input fetch_req_t act);
    checks = checks + 1;
    if (exp !== act)
      begin
      errors = errors + 1;
      $display("MISMATCH %s: expected pc=%h order=%0d taken=%b next=%h", name,
               exp.pc, exp.order, exp.br_taken, exp.pred_next);
      $display("MISMATCH %s: actual   pc=%h order=%0d taken=%b next=%h", name,
               act.pc, act.order, act.br_taken, act.pred_next);
      end
  endtask

  task automatic check_inst(input string name, input logic [XLEN-1:0] exp,
                            input logic [XLEN-1:0] act);
    checks = checks + 1;
    if (exp !== act)
      begin
      errors = errors + 1;
      $display("MISMATCH %s: expected inst=%h, actual inst=%h", name, exp, act);
      end
  endtask

  task automatic check_tags(input string name, input logic exp_tga,
                            input logic [ERA_W-1:0] exp_tgc, input logic act_tga,
                            input logic [ERA_W-1:0] act_tgc);
    checks = checks + 1;
    if (exp_tga !== act_tga || exp_tgc !== act_tgc)
      begin
      errors = errors + 1;
      $display("MISMATCH %s: expected tga=%b tgc=%h, actual tga=%b tgc=%h", name,
               exp_tga, exp_tgc, act_tga, act_tgc);
      end
  endtask

  // Captures transfers and checks that fields hold while decode stalls
  always @(posedge clk)
    begin
    if (!rst)
      begin
      if (held && ifu_vld)
        begin
        check_req({cur_test, " hold"}, held_req, out_req);
        check_inst({cur_test, " hold"}, held_inst, ifu_inst);
        end
      if (ifu_vld && ifu_rdy)
        begin
        cap_req.push_back(out_req);
        cap_inst.push_back(ifu_inst);
        end
      held      = ifu_vld && !ifu_rdy;
      held_req  = out_req;
      held_inst = ifu_inst;
      end
    end

  // Request tags on each accepted request, and the bus cycle while acks are owed
  always @(posedge clk)
    begin
    if (!rst)
      begin
      if (outst != 0 && !bus_cyc)
        begin
        errors = errors + 1;
        $display("%s: bus cycle dropped with %0d requests outstanding", cur_test, outst);
        end
      if (bus_stb && !bus_stall)
        begin
        check_tags({cur_test, " request"}, trn_vld && (bus_adr == trn_pc), exp_era,
                   bus_tga, bus_tgc);
        outst = outst + 1;
        end
      if (bus_ack)
        begin
        outst = outst - 1;
        end
      end
    end

  task automatic redirect(input logic [XLEN-1:0] pc, input logic [ORDER_W-1:0] order);
    exu_pc_next    = pc;
    exu_order_next = order;
    exu_redir      = 1'b1;
    @(posedge clk);
    #1;
    exu_redir = 1'b0;
    exp_era   = exp_era + 1'b1;
    cap_req.delete();
    cap_inst.delete();
  endtask

  task automatic train_btb(input logic [XLEN-1:0] pc, input logic [XLEN-1:0] target);
    exu_upd_pc     = pc;
    exu_upd_target = target;
    exu_upd_vld    = 1'b1;
    @(posedge clk);
    #1;
    exu_upd_vld = 1'b0;
    trn_vld     = 1'b1;
    trn_pc      = pc;
    trn_target  = target;
  endtask

  // Random ready stretches of 1 to 6 cycles when backpress is set
  task automatic collect(input int n, input bit backpress);
    int hold;
    hold = 0;
    while (cap_req.size() < n)
      begin
      if (backpress)
        begin
        if (hold == 0)
          begin
          ifu_rdy = $random(seed) & 1;
          hold    = 1 + ($unsigned($random(seed)) % 6);
          end
        hold = hold - 1;
        end
      @(posedge clk);
      #1;
      end
    ifu_rdy = 1'b1;
  endtask

  task automatic verify_stream(input int n, input logic [XLEN-1:0] start_pc,
                               input logic [ORDER_W-1:0] start_order);
    fetch_req_t         exp;
    logic [XLEN-1:0]    pc;
    logic [ORDER_W-1:0] order;
    pc    = start_pc;
    order = start_order;
    for (int i = 0; i < n; i++)
      begin
      exp.order     = order;
      exp.pc        = pc;
      exp.br_taken  = trn_vld && (pc == trn_pc);
      exp.pred_next = exp.br_taken ? trn_target : pc + 32'd4;
      check_req(cur_test, exp, cap_req[i]);
      check_inst(cur_test, pc ^ 32'h5a5a0000, cap_inst[i]);
      pc    = exp.pred_next;
      order = order + 1;
      end
  endtask

  task automatic report_test(input int n);
    tests_run = tests_run + 1;
    $display("%s: %0d transfers, %0d errors", cur_test, n, errors - err_base);
  endtask

  task automatic test_seq_fetch();
    cur_test = "seq_fetch";
    err_base = errors;
    repeat (10) @(posedge clk);
    #1;
    if (bus_stb || bus_cyc || ifu_vld)
      begin
      errors = errors + 1;
      $display("seq_fetch: bus or delivery active while in reset");
      end
    rst = 1'b0;
    collect(20, 1'b0);
    verify_stream(20, 32'h0, 64'd0);
    report_test(20);
  endtask

  task automatic test_branch();
    cur_test = "branch";
    err_base = errors;
    train_btb(32'h20, 32'h100);
    redirect(32'h0, 64'd0);
    collect(12, 1'b0);
    verify_stream(12, 32'h0, 64'd0);
    report_test(12);
  endtask

  task automatic test_redirect_inflight();
    cur_test = "redirect_inflight";
    err_base = errors;
    redirect(32'h400, 64'd1000);
    collect(3, 1'b0);
    if (outst == 0)
      begin
      errors = errors + 1;
      $display("redirect_inflight: no request outstanding at the redirect");
      end
    redirect(32'h800, 64'd5000);
    collect(12, 1'b0);
    verify_stream(12, 32'h800, 64'd5000);
    report_test(12);
  endtask

  task automatic test_backpressure();
    cur_test = "backpressure";
    err_base = errors;
    redirect(32'h2000, 64'd2000);
    collect(30, 1'b1);
    verify_stream(30, 32'h2000, 64'd2000);
    report_test(30);
  endtask

  task automatic test_bus_stall();
    cur_test = "bus_stall";
    err_base = errors;
    stall_en = 1'b1;
    redirect(32'h3000, 64'd3000);
    collect(25, 1'b0);
    stall_en = 1'b0;
    verify_stream(25, 32'h3000, 64'd3000);
    report_test(25);
  endtask

  initial
    begin
    rst            = 1'b1;
    exu_redir      = 1'b0;
    exu_pc_next    = '0;
    exu_order_next = '0;
    exu_upd_vld    = 1'b0;
    exu_upd_pc     = '0;
    exu_upd_target = '0;
    stall_en       = 1'b0;
    ifu_rdy        = 1'b1;
    test_seq_fetch();
    test_branch();
    test_redirect_inflight();
    test_backpressure();
    test_bus_stall();
    $display("Tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0)
      begin
      $display("PASS: all tests");
      end
    else
      begin
      $display("FAIL: see errors above");
      end
    $finish;
    end

endmodule

`default_nettype wire

/* list.f */
src/ifu_pkg.sv
src/ifu_fifo.sv
src/ifu_btb.sv
src/ifu_fetch_ctrl.sv
src/ifu_deliver.sv
src/ifu_top.sv
tests/ifu_bus_model.sv
tests/ifu_tb.sv
